// File: Makefile
# Verilator build for the Wishbone interconnect testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_interconnect
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_wb_interconnect.sv
`timescale 1ns/1ps

module tb_wb_interconnect import wb_ic_pkg::*; ();

  localparam int TMO = 400;

  logic     clk_i = 1'b0;
  logic     rst_n_i = 1'b0;
  // Master side, indexed by master number
  wb_dat_t  m_dat  [3];
  wb_dat_t  m_rdat [3];
  wb_adr_t  m_adr  [3];
  wb_sel_t  m_sel  [3];
  logic     m_we   [3];
  logic     m_cyc  [3];
  logic     m_stb  [3];
  logic     m_ack  [3];
  // Slave side, indexed by slave number
  wb_dat_t  s_dat  [4];
  wb_dat_t  s_rdat [4];
  wb_adr_t  s_adr  [4];
  wb_sel_t  s_sel  [4];
  logic     s_we   [4];
  logic     s_cyc  [4];
  logic     s_stb  [4];
  logic     s_ack  [4];
  reg_adr_t s2_adr8;
  reg_adr_t s3_adr8;
  // Slave model state
  int       busy [4];
  int       dly  [4];
  int       max_dly;
  wb_adr_t  cap_adr [4];
  wb_dat_t  cap_dat [4];
  wb_sel_t  cap_sel [4];
  logic     cap_we  [4];
  // Master cyc as the DUT saw it at the last rising edge
  logic     cyc_seen [3];
  // Slave log with one entry per stb seen
  int       lg_slv [$];
  wb_adr_t  lg_adr [$];
  wb_dat_t  lg_dat [$];
  wb_sel_t  lg_sel [$];
  logic     lg_we  [$];
  // Completed master transfers
  wb_adr_t  cp_adr  [$];
  wb_dat_t  cp_dat  [$];
  wb_dat_t  cp_rdat [$];
  wb_sel_t  cp_sel  [$];
  logic     cp_we   [$];
  int       order_q [$];
  string    test_name;

  initial begin
    forever #5 clk_i = ~clk_i;
  end

  assign s_adr[2] = {24'h0, s2_adr8};
  assign s_adr[3] = {24'h0, s3_adr8};

  wb_interconnect u_wb_interconnect (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .m0_wbd_dat_i(m_dat[0]), .m0_wbd_adr_i(m_adr[0]), .m0_wbd_sel_i(m_sel[0]),
    .m0_wbd_we_i(m_we[0]), .m0_wbd_cyc_i(m_cyc[0]), .m0_wbd_stb_i(m_stb[0]),
    .m0_wbd_dat_o(m_rdat[0]), .m0_wbd_ack_o(m_ack[0]),
    .m1_wbd_dat_i(m_dat[1]), .m1_wbd_adr_i(m_adr[1]), .m1_wbd_sel_i(m_sel[1]),
    .m1_wbd_we_i(m_we[1]), .m1_wbd_cyc_i(m_cyc[1]), .m1_wbd_stb_i(m_stb[1]),
    .m1_wbd_dat_o(m_rdat[1]), .m1_wbd_ack_o(m_ack[1]),
    .m2_wbd_dat_i(m_dat[2]), .m2_wbd_adr_i(m_adr[2]), .m2_wbd_sel_i(m_sel[2]),
    .m2_wbd_we_i(m_we[2]), .m2_wbd_cyc_i(m_cyc[2]), .m2_wbd_stb_i(m_stb[2]),
    .m2_wbd_dat_o(m_rdat[2]), .m2_wbd_ack_o(m_ack[2]),
    .s0_wbd_dat_o(s_dat[0]), .s0_wbd_adr_o(s_adr[0]), .s0_wbd_sel_o(s_sel[0]),
    .s0_wbd_we_o(s_we[0]), .s0_wbd_cyc_o(s_cyc[0]), .s0_wbd_stb_o(s_stb[0]),
    .s0_wbd_dat_i(s_rdat[0]), .s0_wbd_ack_i(s_ack[0]),
    .s1_wbd_dat_o(s_dat[1]), .s1_wbd_adr_o(s_adr[1]), .s1_wbd_sel_o(s_sel[1]),
    .s1_wbd_we_o(s_we[1]), .s1_wbd_cyc_o(s_cyc[1]), .s1_wbd_stb_o(s_stb[1]),
    .s1_wbd_dat_i(s_rdat[1]), .s1_wbd_ack_i(s_ack[1]),
    .s2_wbd_dat_o(s_dat[2]), .s2_wbd_adr_o(s2_adr8), .s2_wbd_sel_o(s_sel[2]),
    .s2_wbd_we_o(s_we[2]), .s2_wbd_cyc_o(s_cyc[2]), .s2_wbd_stb_o(s_stb[2]),
    .s2_wbd_dat_i(s_rdat[2]), .s2_wbd_ack_i(s_ack[2]),
    .s3_wbd_dat_o(s_dat[3]), .s3_wbd_adr_o(s3_adr8), .s3_wbd_sel_o(s_sel[3]),
    .s3_wbd_we_o(s_we[3]), .s3_wbd_cyc_o(s_cyc[3]), .s3_wbd_stb_o(s_stb[3]),
    .s3_wbd_dat_i(s_rdat[3]), .s3_wbd_ack_i(s_ack[3])
  );

  // --------------------------------------------------
  // Helpers and reference model
  // --------------------------------------------------
  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic wrong_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    fail_now($sformatf("mismatch %s %s expected %h actual %h", test_name, what, exp, act));
  endtask

  // Slave read data pattern spread over the whole address
  function automatic wb_dat_t rd_pattern(input int slv, input wb_adr_t adr);
    return (adr * 32'h9E37_79B1) ^ {slv[3:0], 28'h5A5_A5A5} ^ (adr >> 13);
  endfunction

  // Expected slave, shaped address and read data for a master address
  function automatic void ref_model(input wb_adr_t adr, output int slv,
                                    output wb_adr_t sadr, output wb_dat_t rdat);
    sadr = adr & 32'hFFFF_FFFC;
    if (adr[31:28] <= 4'h1) slv = 0;
    else if (adr[31:28] == 4'h2) slv = 1;
    else if (adr[31:16] == 16'h3000) slv = 2;
    else if (adr[31:16] == 16'h3001) slv = 3;
    else slv = 0;
    if (slv == 1) sadr = sadr & 32'h0FFF_FFFF;
    if (slv >= 2) sadr = sadr & 32'h0000_00FF;
    rdat = rd_pattern(slv, sadr);
  endfunction

  // Random address from one of the map regions or an unmapped one
  function automatic wb_adr_t rand_adr();
    case ($urandom % 7)
      0: return {4'h0, 28'($urandom)};
      1: return {4'h1, 28'($urandom)};
      2: return {4'h2, 28'($urandom)};
      3: return {16'h3000, 16'($urandom)};
      4: return {16'h3001, 16'($urandom)};
      // Top nibble 3 outside the two register blocks
      5: return {16'(32'h3002 + $urandom % 32'h0FFE), 16'($urandom)};
      default: return {4'(4 + $urandom % 12), 28'($urandom)};
    endcase
  endfunction

  // One classic Wishbone cycle from master m up to its ack
  task automatic do_xfer(input int m, input wb_adr_t adr, input wb_dat_t dat,
                         input wb_sel_t sel, input logic we);
    int cnt;
    @(negedge clk_i);
    m_adr[m] = adr;
    m_dat[m] = dat;
    m_sel[m] = sel;
    m_we[m]  = we;
    m_cyc[m] = 1'b1;
    m_stb[m] = 1'b1;
    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
    end while (!m_ack[m] && cnt < TMO);
    if (!m_ack[m]) fail_now($sformatf("master %0d got no ack in %s", m, test_name));
    cp_adr.push_back(adr);
    cp_dat.push_back(dat);
    cp_sel.push_back(sel);
    cp_we.push_back(we);
    cp_rdat.push_back(m_rdat[m]);
    order_q.push_back(m);
    m_cyc[m] = 1'b0;
    m_stb[m] = 1'b0;
  endtask

  // --------------------------------------------------
  // Slave models and bus monitors
  // --------------------------------------------------
  initial begin
    forever begin
      @(posedge clk_i);
      for (int m = 0; m < 3; m++) begin
        cyc_seen[m] = m_cyc[m];
      end
    end
  end

  initial begin
    forever begin
      @(negedge clk_i);
      for (int i = 0; i < 4; i++) begin
        if (s_ack[i]) begin
          s_ack[i] = 1'b0;
          busy[i]  = 0;
        end else if (s_stb[i] && busy[i] == 0) begin
          busy[i] = 1;
          dly[i]  = $urandom_range(0, max_dly);
          cap_adr[i] = s_adr[i];
          cap_dat[i] = s_dat[i];
          cap_sel[i] = s_sel[i];
          cap_we[i]  = s_we[i];
          lg_slv.push_back(i);
          lg_adr.push_back(s_adr[i]);
          lg_dat.push_back(s_dat[i]);
          lg_sel.push_back(s_sel[i]);
          lg_we.push_back(s_we[i]);
        end else if (busy[i] != 0) begin
          // Request must not move while stalled
          assert (s_stb[i] && s_cyc[i])
            else fail_now($sformatf("slave %0d lost its request while stalled", i));
          assert (s_adr[i] == cap_adr[i])
            else wrong_value("stalled slave adr", cap_adr[i], s_adr[i]);
          assert (s_dat[i] == cap_dat[i])
            else wrong_value("stalled slave dat", cap_dat[i], s_dat[i]);
          assert (s_sel[i] == cap_sel[i])
            else wrong_value("stalled slave sel", 32'(cap_sel[i]), 32'(s_sel[i]));
          assert (s_we[i] == cap_we[i])
            else wrong_value("stalled slave we", 32'(cap_we[i]), 32'(s_we[i]));
          dly[i]--;
        end
        if (busy[i] != 0 && dly[i] <= 0 && !s_ack[i]) begin
          s_ack[i]  = 1'b1;
          s_rdat[i] = rd_pattern(i, s_adr[i]);
        end
      end
      // Acks only for masters with an open cycle
      for (int m = 0; m < 3; m++) begin
        assert (!m_ack[m] || cyc_seen[m])
          else fail_now($sformatf("stray ack on master %0d", m));
      end
    end
  end

  // Comparing process over completed transfers
  initial begin
    int slv;
    wb_adr_t sadr;
    wb_dat_t rdat;
    forever begin
      @(posedge clk_i);
      while (cp_adr.size() > 0) begin
        ref_model(cp_adr[0], slv, sadr, rdat);
        assert (lg_slv.size() > 0) else fail_now("transfer done but no slave saw it");
        assert (lg_slv[0] == slv) else wrong_value("slave", slv, lg_slv[0]);
        assert (lg_adr[0] == sadr) else wrong_value("address", sadr, lg_adr[0]);
        assert (lg_we[0] == cp_we[0])
          else wrong_value("we", 32'(cp_we[0]), 32'(lg_we[0]));
        assert (lg_sel[0] == cp_sel[0])
          else wrong_value("sel", 32'(cp_sel[0]), 32'(lg_sel[0]));
        if (cp_we[0]) begin
          assert (lg_dat[0] == cp_dat[0]) else wrong_value("write data", cp_dat[0], lg_dat[0]);
        end else begin
          assert (cp_rdat[0] == rdat) else wrong_value("read data", rdat, cp_rdat[0]);
        end
        void'(cp_adr.pop_front());
        void'(cp_dat.pop_front());
        void'(cp_sel.pop_front());
        void'(cp_we.pop_front());
        void'(cp_rdat.pop_front());
        void'(lg_slv.pop_front());
        void'(lg_adr.pop_front());
        void'(lg_dat.pop_front());
        void'(lg_sel.pop_front());
        void'(lg_we.pop_front());
      end
    end
  end

  // Expected grant order from the parked owner onward
  function automatic void rr_order(input int park, output int ord[3]);
    for (int k = 0; k < 3; k++) begin
      ord[k] = (park + k) % 3;
    end
  endfunction

  task automatic run_contention(input int park);
    int ord[3];
    order_q.delete();
    fork
      do_xfer(0, rand_adr(), $urandom, 4'hF, 1'b1);
      do_xfer(1, rand_adr(), $urandom, 4'hF, 1'b0);
      do_xfer(2, rand_adr(), $urandom, 4'hF, 1'b1);
    join
    rr_order(park, ord);
    for (int k = 0; k < 3; k++) begin
      assert (order_q[k] == ord[k]) else wrong_value("grant order", ord[k], order_q[k]);
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    int cnt;
    void'($urandom(32'h3593));
    max_dly = 5;
    for (int m = 0; m < 3; m++) begin
      m_dat[m] = '0;
      m_adr[m] = '0;
      m_sel[m] = '0;
      m_we[m]  = 1'b0;
      m_cyc[m] = 1'b0;
      m_stb[m] = 1'b0;
    end
    for (int i = 0; i < 4; i++) begin
      s_ack[i]  = 1'b0;
      s_rdat[i] = '0;
      busy[i]   = 0;
      dly[i]    = 0;
    end
    test_name = "reset";
    for (int c = 0; c < 12; c++) begin
      @(negedge clk_i);
      if (c == 10) rst_n_i = 1'b1;
      for (int i = 0; i < 4; i++) begin
        assert (!s_stb[i] && !s_cyc[i]) else fail_now("slave request active in reset");
      end
      for (int m = 0; m < 3; m++) begin
        assert (!m_ack[m]) else fail_now("master ack active in reset");
      end
    end
    // Contention right after reset and again with the grant parked on m2
    test_name = "round_robin";
    run_contention(0);
    run_contention(2);
    test_name = "routing";
    for (int n = 0; n < 60; n++) do_xfer(n % 3, rand_adr(), $urandom, 4'($urandom), 1'b1);
    test_name = "read_return";
    for (int n = 0; n < 60; n++) do_xfer($urandom % 3, rand_adr(), '0, 4'hF, 1'b0);
    test_name = "back_pressure";
    max_dly = 20;
    for (int n = 0; n < 30; n++) do_xfer($urandom % 3, rand_adr(), $urandom, 4'hF, n[0]);
    // Let the comparing process drain
    cnt = 0;
    while (cp_adr.size() > 0 && cnt < TMO) begin
      @(negedge clk_i);
      cnt++;
    end
    if (cp_adr.size() > 0) fail_now("comparing process did not drain");
    if (lg_slv.size() == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("extra slave requests with no master transfer");
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
wb_ic_pkg.sv
wb_arb.sv
wb_addr_decode.sv
wb_stage.sv
wb_interconnect.sv
wb_interconnect_chk.sv
tb_wb_interconnect.sv

// File: wb_addr_decode.sv
`timescale 1ns/1ps

module wb_addr_decode import wb_ic_pkg::*; (
  // Raw addresses from all masters
  input  wb_adr_t m_adr_i [NUM_MST],
  // Target slave per master
  output tid_t    m_tid_o [NUM_MST],
  // Word-aligned addresses per master
  output wb_adr_t m_adr_o [NUM_MST]
);

  // --------------------------------------------------
  // Memory map
  // --------------------------------------------------
  // 0x0xxx_xxxx  flash
  // 0x1xxx_xxxx  SPI registers, same slave as flash
  // 0x2xxx_xxxx  SDRAM
  // 0x3000_xxxx  global registers
  // 0x3001_xxxx  UART
  // Anything else falls back to slave 0
  function automatic tid_t decode_tid(input wb_adr_t adr);
    logic [3:0]  nib;
    logic [15:0] hi;
    nib = adr[WB_ADR_W-1 -: 4];
    hi  = adr[WB_ADR_W-1 -: 16];
    // Nibble checks first, half-word checks after
    if (nib == MAP_FLASH_NIB || nib == MAP_SPI_NIB) begin
      return TID_FLASH;
    end
    if (nib == MAP_SDRAM_NIB) begin
      return TID_SDRAM;
    end
    if (hi == MAP_GLBL_HI) begin
      return TID_GLBL;
    end
    if (hi == MAP_UART_HI) begin
      return TID_UART;
    end
    return TID_FLASH;
  endfunction

  // Byte offset bits are dropped, slaves see word addresses
  function automatic wb_adr_t word_align(input wb_adr_t adr);
    return {adr[WB_ADR_W-1:2], 2'b00};
  endfunction

  // Same decode applied to every master in parallel
  always_comb begin
    for (int i = 0; i < NUM_MST; i++) begin
      m_tid_o[i] = decode_tid(m_adr_i[i]);
      m_adr_o[i] = word_align(m_adr_i[i]);
    end
  end

endmodule

// File: wb_arb.sv
`timescale 1ns/1ps

module wb_arb import wb_ic_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // One cycle request per master
  input  logic [NUM_MST-1:0] req_i,
  output mst_idx_t           gnt_o
);

  mst_idx_t gnt_q;
  mst_idx_t gnt_nxt;
  mst_idx_t cand;
  logic     found;

  // Next master in circular order
  function automatic mst_idx_t next_mst(input mst_idx_t idx);
    if (idx == mst_idx_t'(NUM_MST - 1)) begin
      return '0;
    end
    return mst_idx_t'(idx + 1'b1);
  endfunction

  // --------------------------------------------------
  // Round-robin search
  // --------------------------------------------------
  // Owner keeps the bus while its cyc is high
  // Once released, walk forward from the owner and take
  // the first master still requesting
  always_comb begin
    gnt_nxt = gnt_q;
    cand    = gnt_q;
    found   = 1'b0;
    if (!req_i[gnt_q]) begin
      for (int i = 0; i < NUM_MST - 1; i++) begin
        cand = next_mst(cand);
        if (req_i[cand] && !found) begin
          gnt_nxt = cand;
          found   = 1'b1;
        end
      end
    end
    // No other requester, grant parks on the last owner
  end

  // Grant register, master 0 owns the bus out of reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gnt_q <= '0;
    end else begin
      gnt_q <= gnt_nxt;
    end
  end

  assign gnt_o = gnt_q;

endmodule

// File: wb_ic_pkg.sv
package wb_ic_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int WB_DAT_W  = 32;
  localparam int WB_ADR_W  = 32;
  localparam int WB_SEL_W  = 4;
  // Register blocks decode only the low byte
  localparam int REG_ADR_W = 8;
  localparam int TID_W     = 2;
  localparam int MST_IDX_W = 2;

  // Port counts, fixed by the top-level port list
  localparam int NUM_MST = 3;
  localparam int NUM_SLV = 4;

  // --------------------------------------------------
  // Vector types
  // --------------------------------------------------
  typedef logic [WB_DAT_W-1:0]  wb_dat_t;
  typedef logic [WB_ADR_W-1:0]  wb_adr_t;
  typedef logic [WB_SEL_W-1:0]  wb_sel_t;
  typedef logic [REG_ADR_W-1:0] reg_adr_t;
  typedef logic [TID_W-1:0]     tid_t;
  typedef logic [MST_IDX_W-1:0] mst_idx_t;

  // Target ids, one per slave port
  localparam tid_t TID_FLASH = 2'd0;
  localparam tid_t TID_SDRAM = 2'd1;
  localparam tid_t TID_GLBL  = 2'd2;
  localparam tid_t TID_UART  = 2'd3;

  // --------------------------------------------------
  // Memory map
  // --------------------------------------------------
  // Top nibble of the address
  localparam logic [3:0] MAP_FLASH_NIB = 4'h0;
  localparam logic [3:0] MAP_SPI_NIB   = 4'h1;
  localparam logic [3:0] MAP_SDRAM_NIB = 4'h2;
  // Upper half-word of the address
  localparam logic [15:0] MAP_GLBL_HI = 16'h3000;
  localparam logic [15:0] MAP_UART_HI = 16'h3001;

  // Staging FSM
  typedef enum logic [1:0] {
    STG_IDLE,
    STG_SLV_REQ,
    STG_MST_ACK
  } stage_state_t;

endpackage

// File: wb_interconnect.sv
`timescale 1ns/1ps

module wb_interconnect import wb_ic_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Master 0, external host
  input  wb_dat_t  m0_wbd_dat_i,
  input  wb_adr_t  m0_wbd_adr_i,
  input  wb_sel_t  m0_wbd_sel_i,
  input  logic     m0_wbd_we_i,
  input  logic     m0_wbd_cyc_i,
  input  logic     m0_wbd_stb_i,
  output wb_dat_t  m0_wbd_dat_o,
  output logic     m0_wbd_ack_o,
  // Master 1, RISC instruction port
  input  wb_dat_t  m1_wbd_dat_i,
  input  wb_adr_t  m1_wbd_adr_i,
  input  wb_sel_t  m1_wbd_sel_i,
  input  logic     m1_wbd_we_i,
  input  logic     m1_wbd_cyc_i,
  input  logic     m1_wbd_stb_i,
  output wb_dat_t  m1_wbd_dat_o,
  output logic     m1_wbd_ack_o,
  // Master 2, RISC data port
  input  wb_dat_t  m2_wbd_dat_i,
  input  wb_adr_t  m2_wbd_adr_i,
  input  wb_sel_t  m2_wbd_sel_i,
  input  logic     m2_wbd_we_i,
  input  logic     m2_wbd_cyc_i,
  input  logic     m2_wbd_stb_i,
  output wb_dat_t  m2_wbd_dat_o,
  output logic     m2_wbd_ack_o,
  // Slave 0, flash and SPI registers
  output wb_dat_t  s0_wbd_dat_o,
  output wb_adr_t  s0_wbd_adr_o,
  output wb_sel_t  s0_wbd_sel_o,
  output logic     s0_wbd_we_o,
  output logic     s0_wbd_cyc_o,
  output logic     s0_wbd_stb_o,
  input  wb_dat_t  s0_wbd_dat_i,
  input  logic     s0_wbd_ack_i,
  // Slave 1, SDRAM
  output wb_dat_t  s1_wbd_dat_o,
  output wb_adr_t  s1_wbd_adr_o,
  output wb_sel_t  s1_wbd_sel_o,
  output logic     s1_wbd_we_o,
  output logic     s1_wbd_cyc_o,
  output logic     s1_wbd_stb_o,
  input  wb_dat_t  s1_wbd_dat_i,
  input  logic     s1_wbd_ack_i,
  // Slave 2, global registers
  output wb_dat_t  s2_wbd_dat_o,
  output reg_adr_t s2_wbd_adr_o,
  output wb_sel_t  s2_wbd_sel_o,
  output logic     s2_wbd_we_o,
  output logic     s2_wbd_cyc_o,
  output logic     s2_wbd_stb_o,
  input  wb_dat_t  s2_wbd_dat_i,
  input  logic     s2_wbd_ack_i,
  // Slave 3, UART
  output wb_dat_t  s3_wbd_dat_o,
  output reg_adr_t s3_wbd_adr_o,
  output wb_sel_t  s3_wbd_sel_o,
  output logic     s3_wbd_we_o,
  output logic     s3_wbd_cyc_o,
  output logic     s3_wbd_stb_o,
  input  wb_dat_t  s3_wbd_dat_i,
  input  logic     s3_wbd_ack_i
);

  wb_adr_t            m_adr_raw [NUM_MST];
  wb_adr_t            m_adr_al  [NUM_MST];
  tid_t               m_tid     [NUM_MST];
  mst_idx_t           gnt;
  // Granted master request
  wb_dat_t            mux_dat;
  wb_adr_t            mux_adr;
  wb_sel_t            mux_sel;
  logic               mux_we;
  logic               mux_cyc;
  logic               mux_stb;
  tid_t               mux_tid;
  // Staged request and response
  wb_dat_t            stg_m_dat;
  logic               stg_m_ack;
  wb_dat_t            stg_s_dat;
  wb_adr_t            stg_s_adr;
  wb_sel_t            stg_s_sel;
  logic               stg_s_we;
  logic               stg_s_cyc;
  logic               stg_s_stb;
  tid_t               stg_s_tid;
  // Selected slave response
  wb_dat_t            slv_dat;
  logic               slv_ack;
  logic [NUM_SLV-1:0] s_hit;

  assign m_adr_raw[0] = m0_wbd_adr_i;
  assign m_adr_raw[1] = m1_wbd_adr_i;
  assign m_adr_raw[2] = m2_wbd_adr_i;

  // --------------------------------------------------
  // Arbitration and decode
  // --------------------------------------------------
  wb_arb u_wb_arb (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   ({m2_wbd_cyc_i, m1_wbd_cyc_i, m0_wbd_cyc_i}),
    .gnt_o   (gnt)
  );

  wb_addr_decode u_wb_addr_decode (
    .m_adr_i (m_adr_raw),
    .m_tid_o (m_tid),
    .m_adr_o (m_adr_al)
  );

  // Master mux, master 0 unless the grant says otherwise
  always_comb begin
    mux_dat = m0_wbd_dat_i;
    mux_adr = m_adr_al[0];
    mux_sel = m0_wbd_sel_i;
    mux_we  = m0_wbd_we_i;
    mux_cyc = m0_wbd_cyc_i;
    mux_stb = m0_wbd_stb_i;
    mux_tid = m_tid[0];
    case (gnt)
      mst_idx_t'(1): begin
        mux_dat = m1_wbd_dat_i;
        mux_adr = m_adr_al[1];
        mux_sel = m1_wbd_sel_i;
        mux_we  = m1_wbd_we_i;
        mux_cyc = m1_wbd_cyc_i;
        mux_stb = m1_wbd_stb_i;
        mux_tid = m_tid[1];
      end
      mst_idx_t'(2): begin
        mux_dat = m2_wbd_dat_i;
        mux_adr = m_adr_al[2];
        mux_sel = m2_wbd_sel_i;
        mux_we  = m2_wbd_we_i;
        mux_cyc = m2_wbd_cyc_i;
        mux_stb = m2_wbd_stb_i;
        mux_tid = m_tid[2];
      end
      default: begin
      end
    endcase
  end

  // Flops on both directions between master mux and slaves
  wb_stage u_wb_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .m_dat_i (mux_dat),
    .m_adr_i (mux_adr),
    .m_sel_i (mux_sel),
    .m_we_i  (mux_we),
    .m_cyc_i (mux_cyc),
    .m_stb_i (mux_stb),
    .m_tid_i (mux_tid),
    .m_dat_o (stg_m_dat),
    .m_ack_o (stg_m_ack),
    .s_dat_o (stg_s_dat),
    .s_adr_o (stg_s_adr),
    .s_sel_o (stg_s_sel),
    .s_we_o  (stg_s_we),
    .s_cyc_o (stg_s_cyc),
    .s_stb_o (stg_s_stb),
    .s_tid_o (stg_s_tid),
    .s_dat_i (slv_dat),
    .s_ack_i (slv_ack)
  );

  // --------------------------------------------------
  // Slave fan-out by staged tid
  // --------------------------------------------------
  assign s_hit[0] = (stg_s_tid == TID_FLASH);
  assign s_hit[1] = (stg_s_tid == TID_SDRAM);
  assign s_hit[2] = (stg_s_tid == TID_GLBL);
  assign s_hit[3] = (stg_s_tid == TID_UART);

  assign s0_wbd_dat_o = s_hit[0] ? stg_s_dat : '0;
  assign s0_wbd_adr_o = s_hit[0] ? stg_s_adr : '0;
  assign s0_wbd_sel_o = s_hit[0] ? stg_s_sel : '0;
  assign s0_wbd_we_o  = s_hit[0] & stg_s_we;
  assign s0_wbd_cyc_o = s_hit[0] & stg_s_cyc;
  assign s0_wbd_stb_o = s_hit[0] & stg_s_stb;

  // SDRAM window starts at zero on its own side
  assign s1_wbd_dat_o = s_hit[1] ? stg_s_dat : '0;
  assign s1_wbd_adr_o = s_hit[1] ? {4'h0, stg_s_adr[WB_ADR_W-5:0]} : '0;
  assign s1_wbd_sel_o = s_hit[1] ? stg_s_sel : '0;
  assign s1_wbd_we_o  = s_hit[1] & stg_s_we;
  assign s1_wbd_cyc_o = s_hit[1] & stg_s_cyc;
  assign s1_wbd_stb_o = s_hit[1] & stg_s_stb;

  // Register blocks take the low byte only
  assign s2_wbd_dat_o = s_hit[2] ? stg_s_dat : '0;
  assign s2_wbd_adr_o = s_hit[2] ? stg_s_adr[REG_ADR_W-1:0] : '0;
  assign s2_wbd_sel_o = s_hit[2] ? stg_s_sel : '0;
  assign s2_wbd_we_o  = s_hit[2] & stg_s_we;
  assign s2_wbd_cyc_o = s_hit[2] & stg_s_cyc;
  assign s2_wbd_stb_o = s_hit[2] & stg_s_stb;

  assign s3_wbd_dat_o = s_hit[3] ? stg_s_dat : '0;
  assign s3_wbd_adr_o = s_hit[3] ? stg_s_adr[REG_ADR_W-1:0] : '0;
  assign s3_wbd_sel_o = s_hit[3] ? stg_s_sel : '0;
  assign s3_wbd_we_o  = s_hit[3] & stg_s_we;
  assign s3_wbd_cyc_o = s_hit[3] & stg_s_cyc;
  assign s3_wbd_stb_o = s_hit[3] & stg_s_stb;

  // Response from the slave the staged request went to
  always_comb begin
    slv_dat = s0_wbd_dat_i;
    slv_ack = s0_wbd_ack_i;
    case (stg_s_tid)
      TID_SDRAM: begin
        slv_dat = s1_wbd_dat_i;
        slv_ack = s1_wbd_ack_i;
      end
      TID_GLBL: begin
        slv_dat = s2_wbd_dat_i;
        slv_ack = s2_wbd_ack_i;
      end
      TID_UART: begin
        slv_dat = s3_wbd_dat_i;
        slv_ack = s3_wbd_ack_i;
      end
      default: begin
      end
    endcase
  end

  // Response only reaches the granted master
  assign m0_wbd_dat_o = (gnt == mst_idx_t'(0)) ? stg_m_dat : '0;
  assign m0_wbd_ack_o = (gnt == mst_idx_t'(0)) & stg_m_ack;
  assign m1_wbd_dat_o = (gnt == mst_idx_t'(1)) ? stg_m_dat : '0;
  assign m1_wbd_ack_o = (gnt == mst_idx_t'(1)) & stg_m_ack;
  assign m2_wbd_dat_o = (gnt == mst_idx_t'(2)) ? stg_m_dat : '0;
  assign m2_wbd_ack_o = (gnt == mst_idx_t'(2)) & stg_m_ack;

endmodule

// File: wb_interconnect_chk.sv
`timescale 1ns/1ps

module wb_interconnect_chk import wb_ic_pkg::*; (
  input logic     clk_i,
  input logic     rst_n_i,
  input logic     m0_wbd_ack_o,
  input logic     m1_wbd_ack_o,
  input logic     m2_wbd_ack_o,
  input logic     s0_wbd_stb_o,
  input logic     s1_wbd_stb_o,
  input logic     s2_wbd_stb_o,
  input logic     s3_wbd_stb_o,
  input mst_idx_t gnt,
  input logic     stg_s_cyc,
  input logic     stg_m_ack
);

  // --------------------------------------------------
  // Master ack pulses are a single cycle
  // --------------------------------------------------
  ack0_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m0_wbd_ack_o |=> !m0_wbd_ack_o) else $error("m0 ack longer than one cycle");
  ack1_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m1_wbd_ack_o |=> !m1_wbd_ack_o) else $error("m1 ack longer than one cycle");
  ack2_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m2_wbd_ack_o |=> !m2_wbd_ack_o) else $error("m2 ack longer than one cycle");

  // Only one slave is addressed at a time
  stb_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({s3_wbd_stb_o, s2_wbd_stb_o, s1_wbd_stb_o, s0_wbd_stb_o}))
    else $error("more than one slave stb high");

  // Grant stays on the issuing master until its ack is out
  ack_on_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (stg_s_cyc || stg_m_ack) |-> $stable(gnt))
    else $error("grant moved during a transfer");

endmodule

bind wb_interconnect wb_interconnect_chk u_wb_interconnect_chk (.*);

// File: wb_stage.sv
`timescale 1ns/1ps

module wb_stage import wb_ic_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Granted master side
  input  wb_dat_t m_dat_i,
  input  wb_adr_t m_adr_i,
  input  wb_sel_t m_sel_i,
  input  logic    m_we_i,
  input  logic    m_cyc_i,
  input  logic    m_stb_i,
  input  tid_t    m_tid_i,
  output wb_dat_t m_dat_o,
  output logic    m_ack_o,
  // Selected slave side
  output wb_dat_t s_dat_o,
  output wb_adr_t s_adr_o,
  output wb_sel_t s_sel_o,
  output logic    s_we_o,
  output logic    s_cyc_o,
  output logic    s_stb_o,
  output tid_t    s_tid_o,
  input  wb_dat_t s_dat_i,
  input  logic    s_ack_i
);

  stage_state_t state_q;
  logic         s_cyc_q;
  logic         s_stb_q;
  tid_t         s_tid_q;
  wb_dat_t      s_dat_q;
  wb_adr_t      s_adr_q;
  wb_sel_t      s_sel_q;
  logic         s_we_q;
  wb_dat_t      m_dat_q;
  logic         req_take;
  logic         rsp_take;

  // New request accepted only from idle
  assign req_take = (state_q == STG_IDLE) && m_cyc_i && m_stb_i;
  // Slave response while the request is out
  assign rsp_take = (state_q == STG_SLV_REQ) && s_ack_i;

  // --------------------------------------------------
  // Control FSM
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= STG_IDLE;
      s_cyc_q <= 1'b0;
      s_stb_q <= 1'b0;
      s_tid_q <= TID_FLASH;
    end else begin
      case (state_q)
        STG_IDLE: begin
          if (req_take) begin
            s_cyc_q <= 1'b1;
            s_stb_q <= 1'b1;
            s_tid_q <= m_tid_i;
            state_q <= STG_SLV_REQ;
          end
        end
        // Holds here for as long as the slave stalls
        STG_SLV_REQ: begin
          if (rsp_take) begin
            s_cyc_q <= 1'b0;
            s_stb_q <= 1'b0;
            state_q <= STG_MST_ACK;
          end
        end
        // Single-cycle ack toward the master
        STG_MST_ACK: state_q <= STG_IDLE;
        default:     state_q <= STG_IDLE;
      endcase
    end
  end

  // Request fields and read data
  always_ff @(posedge clk_i) begin
    if (req_take) begin
      s_dat_q <= m_dat_i;
      s_adr_q <= m_adr_i;
      s_sel_q <= m_sel_i;
      s_we_q  <= m_we_i;
    end
    if (rsp_take) begin
      m_dat_q <= s_dat_i;
    end
  end

  assign s_dat_o = s_dat_q;
  assign s_adr_o = s_adr_q;
  assign s_sel_o = s_sel_q;
  assign s_we_o  = s_we_q;
  assign s_cyc_o = s_cyc_q;
  assign s_stb_o = s_stb_q;
  assign s_tid_o = s_tid_q;

  assign m_dat_o = m_dat_q;
  assign m_ack_o = (state_q == STG_MST_ACK);

endmodule
